// File: hdl/act_params.svh
`ifndef ACT_PARAMS_SVH
`define ACT_PARAMS_SVH

// lane count and input format.
`define ACT_LANES 4
`define ACT_DATA_W 8
`define ACT_FRAC_W 3

// coefficient format.
`define ACT_COEF_W 16
`define ACT_COEF_FRAC 14

// piecewise segments over integer parts -4 to 3.
`define ACT_SEG_N 8

// output keeps full precision, 20 fractional bits.
`define ACT_OUT_W (`ACT_DATA_W + `ACT_COEF_W + 2 * `ACT_FRAC_W)

`endif

// File: hdl/act_pkg.sv
`default_nettype none

`include "act_params.svh"

package act_pkg;

    typedef logic signed [`ACT_DATA_W-1:0] sample_t;
    typedef logic signed [`ACT_OUT_W-1:0] out_sample_t;

    typedef sample_t [`ACT_LANES-1:0] in_vec_t;
    typedef out_sample_t [`ACT_LANES-1:0] out_vec_t;

    typedef struct packed {
        logic signed [`ACT_COEF_W-1:0] a;
        logic signed [`ACT_COEF_W-1:0] b;
        logic signed [`ACT_COEF_W-1:0] c;
    } gelu_coef_t;

    typedef gelu_coef_t [`ACT_LANES-1:0] coef_vec_t;

    // code 2'b11 is never produced.
    typedef enum logic [1:0] {
        REG_ZERO = 2'd0,
        REG_POLY = 2'd1,
        REG_PASS = 2'd2
    } gelu_region_t;

    typedef struct packed {
        gelu_region_t region;
        sample_t      x;
    } lane_x_t;

    typedef lane_x_t [`ACT_LANES-1:0] lane_x_vec_t;

    // fitted triples, index 0 covers integer part -4.
    localparam gelu_coef_t GELU_COEF_TABLE [0:`ACT_SEG_N-1] = '{
        '{a: 16'hFFAF, b: 16'hFD91, c: 16'hFB4C},
        '{a: 16'hFDA5, b: 16'hF1A8, c: 16'hE9E1},
        '{a: 16'hFF64, b: 16'hF68F, c: 16'hECC9},
        '{a: 16'h1329, b: 16'h1CA9, c: 16'hFFAF},
        '{a: 16'h135B, b: 16'h2325, c: 16'hFFB9},
        '{a: 16'hFF80, b: 16'h491B, c: 16'hED09},
        '{a: 16'hFD9D, b: 16'h4E7D, c: 16'hE9B4},
        '{a: 16'hFFAD, b: 16'h427F, c: 16'hFB31}
    };

endpackage

`default_nettype wire

// File: hdl/gelu_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gelu_pipe_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic in_valid,
    input  wire logic out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output logic      s1_en,
    output logic      s2_en
);

    logic s1_valid;

    // output stage moves when empty or drained.
    assign s2_en = !out_valid || out_ready;

    // stage one moves when empty or when stage two takes its word.
    assign s1_en = !s1_valid || s2_en;

    assign in_ready = s1_en;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (s1_en)
            begin
                s1_valid <= in_valid;
            end
            if (s2_en)
            begin
                out_valid <= s1_valid;
            end
        end
    end

    a_out_hold : assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped during a stall");

endmodule

`default_nettype wire

// File: hdl/gelu_coef_lut.sv
`timescale 1ns/1ps
`default_nettype none

`include "act_params.svh"

module gelu_coef_lut (
    input  wire logic             clk,
    input  wire logic             s1_en,
    input  wire act_pkg::in_vec_t in_data,
    output act_pkg::coef_vec_t    coef
);

    import act_pkg::*;

    localparam int SEG_W = $clog2(`ACT_SEG_N);

    logic [SEG_W-1:0] seg_idx [`ACT_LANES];

    // low integer bits offset by half the table, wraps mod 8.
    always_comb
    begin
        for (int i = 0; i < `ACT_LANES; i++)
        begin
            seg_idx[i] = in_data[i][`ACT_FRAC_W +: SEG_W] + SEG_W'(`ACT_SEG_N / 2);
        end
    end

    // one table read per lane.
    always_ff @(posedge clk)
    begin
        if (s1_en)
        begin
            for (int i = 0; i < `ACT_LANES; i++)
            begin
                coef[i] <= GELU_COEF_TABLE[seg_idx[i]];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/gelu_range_classify.sv
`timescale 1ns/1ps
`default_nettype none

`include "act_params.svh"

module gelu_range_classify (
    input  wire logic             clk,
    input  wire logic             s1_en,
    input  wire act_pkg::in_vec_t in_data,
    output act_pkg::lane_x_vec_t  lane_x
);

    import act_pkg::*;

    localparam int INT_W = `ACT_DATA_W - `ACT_FRAC_W;

    localparam logic signed [INT_W-1:0] PASS_MIN = 4;
    localparam logic signed [INT_W-1:0] ZERO_MAX = -4;

    logic signed [INT_W-1:0] int_part [`ACT_LANES];
    gelu_region_t            region_nxt [`ACT_LANES];

    always_comb
    begin
        for (int i = 0; i < `ACT_LANES; i++)
        begin
            int_part[i] = in_data[i][`ACT_DATA_W-1:`ACT_FRAC_W];
            if (int_part[i] >= PASS_MIN)
                region_nxt[i] = REG_PASS;
            else if (int_part[i] <= ZERO_MAX)
                region_nxt[i] = REG_ZERO;
            else
                region_nxt[i] = REG_POLY;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s1_en)
        begin
            for (int i = 0; i < `ACT_LANES; i++)
            begin
                lane_x[i].region <= region_nxt[i];
                lane_x[i].x      <= in_data[i];
            end
        end
    end

    // pass only for positive samples, zero only for negative ones.
    for (genvar g = 0; g < `ACT_LANES; g++)
    begin : g_chk
        a_region_legal : assert property (@(posedge clk)
            s1_en |=> lane_x[g].region inside {REG_ZERO, REG_POLY, REG_PASS}
                && (lane_x[g].region != REG_PASS || !lane_x[g].x[`ACT_DATA_W-1])
                && (lane_x[g].region != REG_ZERO || lane_x[g].x[`ACT_DATA_W-1]))
            else $error("lane %0d holds a region code that does not fit its sample", g);
    end

endmodule

`default_nettype wire

// File: hdl/gelu_poly_eval.sv
`timescale 1ns/1ps
`default_nettype none

`include "act_params.svh"

module gelu_poly_eval (
    input  wire logic                clk,
    input  wire logic                s2_en,
    input  wire act_pkg::coef_vec_t  coef,
    input  wire act_pkg::lane_x_vec_t lane_x,
    output act_pkg::out_vec_t        out_data
);

    import act_pkg::*;

    localparam int OUT_W = `ACT_OUT_W;
    localparam int SQ_W  = 2 * `ACT_DATA_W;

    // every term is aligned to 20 fractional bits.
    localparam int BX_SHIFT   = `ACT_FRAC_W;
    localparam int C_SHIFT    = 2 * `ACT_FRAC_W;
    localparam int PASS_SHIFT = `ACT_COEF_FRAC + `ACT_FRAC_W;

    logic signed [SQ_W-1:0] x_sq     [`ACT_LANES];
    out_sample_t            ax2      [`ACT_LANES];
    out_sample_t            bx       [`ACT_LANES];
    out_sample_t            bx_s     [`ACT_LANES];
    out_sample_t            c_s      [`ACT_LANES];
    out_sample_t            poly_sum [`ACT_LANES];
    out_sample_t            pass_val [`ACT_LANES];
    out_sample_t            lane_y   [`ACT_LANES];

    // products for the poly range fit the output width.
    always_comb
    begin
        for (int i = 0; i < `ACT_LANES; i++)
        begin
            x_sq[i] = SQ_W'(lane_x[i].x) * SQ_W'(lane_x[i].x);
            ax2[i]  = OUT_W'(coef[i].a) * OUT_W'(x_sq[i]);
            bx[i]   = OUT_W'(coef[i].b) * OUT_W'(lane_x[i].x);
        end
    end

    always_comb
    begin
        for (int i = 0; i < `ACT_LANES; i++)
        begin
            bx_s[i]     = bx[i] <<< BX_SHIFT;
            c_s[i]      = OUT_W'(coef[i].c) <<< C_SHIFT;
            poly_sum[i] = ax2[i] + bx_s[i] + c_s[i];
            pass_val[i] = OUT_W'(lane_x[i].x) <<< PASS_SHIFT;
        end
    end

    // region select.
    always_comb
    begin
        for (int i = 0; i < `ACT_LANES; i++)
        begin
            case (lane_x[i].region)
                REG_POLY:
                    lane_y[i] = poly_sum[i];
                REG_PASS:
                    lane_y[i] = pass_val[i];
                default:
                    lane_y[i] = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (s2_en)
        begin
            for (int i = 0; i < `ACT_LANES; i++)
            begin
                out_data[i] <= lane_y[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/gelu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module gelu_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire act_pkg::in_vec_t  in_data,
    input  wire logic              in_valid,
    input  wire logic              out_ready,
    output logic                   in_ready,
    output act_pkg::out_vec_t      out_data,
    output logic                   out_valid
);

    import act_pkg::*;

    logic        s1_en;
    logic        s2_en;
    coef_vec_t   coef;
    lane_x_vec_t lane_x;

    gelu_pipe_ctrl pipe_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .s1_en     (s1_en),
        .s2_en     (s2_en)
    );

    // stage one, coefficient fetch and range check side by side.
    gelu_coef_lut coef_lut_i (
        .clk     (clk),
        .s1_en   (s1_en),
        .in_data (in_data),
        .coef    (coef)
    );

    gelu_range_classify range_classify_i (
        .clk     (clk),
        .s1_en   (s1_en),
        .in_data (in_data),
        .lane_x  (lane_x)
    );

    // stage two.
    gelu_poly_eval poly_eval_i (
        .clk      (clk),
        .s2_en    (s2_en),
        .coef     (coef),
        .lane_x   (lane_x),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

// File: verification/gelu_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "act_params.svh"

module gelu_unit_tb;

    import act_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int N_FIXED         = 8;
    localparam int N_RAND          = 16;
    localparam int N_STIM          = N_FIXED + N_RAND;
    localparam int WATCHDOG_CYCLES = N_STIM * 20;
    localparam int OUT_FRAC        = 2 * `ACT_FRAC_W + `ACT_COEF_FRAC;
    localparam int SEG_W           = $clog2(`ACT_SEG_N);

    logic     clk;
    logic     rst;
    in_vec_t  in_data;
    logic     in_valid;
    logic     out_ready;
    logic     in_ready;
    out_vec_t out_data;
    logic     out_valid;

    int       seed;
    int       errors;
    string    names [N_STIM];
    in_vec_t  stim  [N_STIM];
    out_vec_t exp_q [$];
    string    name_q [$];

    gelu_unit gelu_unit_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fixed-point result of one lane with 20 fractional bits.
    function automatic out_sample_t lane_model(sample_t x);
        int               int_part;
        logic [SEG_W-1:0] seg;
        gelu_coef_t       cf;
        longint           xv;
        longint           acc;
        xv = longint'(x);
        int_part = int'(x) >>> `ACT_FRAC_W;
        if (int_part >= 4)
            acc = xv <<< (OUT_FRAC - `ACT_FRAC_W);
        else if (int_part <= -4)
            acc = 0;
        else
        begin
            seg = SEG_W'((int_part + `ACT_SEG_N / 2) % `ACT_SEG_N);
            cf  = GELU_COEF_TABLE[seg];
            // a*x^2 has 20 fractional bits, b*x 17, c 14.
            acc = longint'(cf.a) * xv * xv;
            acc = acc + ((longint'(cf.b) * xv) <<< (OUT_FRAC - `ACT_COEF_FRAC - `ACT_FRAC_W));
            acc = acc + (longint'(cf.c) <<< (OUT_FRAC - `ACT_COEF_FRAC));
        end
        return out_sample_t'(acc);
    endfunction

    function automatic out_vec_t word_model(in_vec_t w);
        out_vec_t y;
        for (int i = 0; i < `ACT_LANES; i++)
        begin
            y[i] = lane_model(w[i]);
        end
        return y;
    endfunction

    function automatic in_vec_t pack_lanes(int l0, int l1, int l2, int l3);
        in_vec_t w;
        w[0] = sample_t'(l0);
        w[1] = sample_t'(l1);
        w[2] = sample_t'(l2);
        w[3] = sample_t'(l3);
        return w;
    endfunction

    task automatic check_vec(input string name, input out_vec_t exp, input out_vec_t act);
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    // samples are in eighths.
    task automatic load_table();
        names[0] = "pass_pos";
        stim[0]  = pack_lanes(32, 44, 80, 127);
        names[1] = "zero_neg";
        stim[1]  = pack_lanes(-32, -33, -80, -128);
        names[2] = "seg_neg";
        stim[2]  = pack_lanes(-24, -17, -9, -1);
        names[3] = "seg_pos";
        stim[3]  = pack_lanes(0, 7, 15, 31);
        names[4] = "seg_mid";
        stim[4]  = pack_lanes(-16, -8, 8, 24);
        names[5] = "seg_fine";
        stim[5]  = pack_lanes(-20, -12, 3, 20);
        names[6] = "mixed";
        stim[6]  = pack_lanes(32, -32, 12, -31);
        names[7] = "edges";
        stim[7]  = pack_lanes(31, 33, -31, -33);
        for (int i = N_FIXED; i < N_STIM; i++)
        begin
            names[i] = $sformatf("random_%0d", i - N_FIXED);
            stim[i]  = in_vec_t'($random(seed));
        end
    endtask

    // one pass over the table; inputs change on the falling edge and the
    // handshake is sampled 1 ns later, where nothing moves until the next rise.
    task automatic run_pass(input bit random_bp);
        int       idx;
        int       outs;
        bit       fire_in;
        bit       fire_out;
        bit       hist1;
        bit       hist2;
        bit       held_valid;
        out_vec_t held_data;
        idx        = 0;
        outs       = 0;
        hist1      = 1'b0;
        hist2      = 1'b0;
        held_valid = 1'b0;
        held_data  = '0;
        while (outs < N_STIM)
        begin
            @(negedge clk);
            if (random_bp)
                out_ready = ($random(seed) % 2) != 0;
            else
                out_ready = 1'b1;
            if (idx < N_STIM)
            begin
                in_valid = random_bp ? (($random(seed) % 4) != 0) : 1'b1;
                in_data  = stim[idx];
            end
            else
            begin
                in_valid = 1'b0;
                in_data  = '0;
            end
            #1;
            if (held_valid)
            begin
                check_flag("stall hold valid", 1'b1, out_valid);
                check_vec("stall hold data", held_data, out_data);
            end
            // with no back-pressure, out_valid follows acceptance by two edges.
            if (!random_bp)
            begin
                check_flag("latency", hist2, out_valid);
                check_flag("full rate in_ready", 1'b1, in_ready);
            end
            fire_in  = in_valid && in_ready;
            fire_out = out_valid && out_ready;
            if (fire_out)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("an output word was accepted with no input word outstanding");
                end
                else
                    check_vec(name_q.pop_front(), exp_q.pop_front(), out_data);
                outs++;
            end
            if (fire_in)
            begin
                exp_q.push_back(word_model(stim[idx]));
                name_q.push_back(names[idx]);
                idx++;
            end
            held_valid = out_valid && !out_ready;
            held_data  = out_data;
            hist2      = hist1;
            hist1      = fire_in;
        end
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the outputs did not all arrive", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        seed      = 32'hec7959a2;
        errors    = 0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        in_data   = '0;
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset in_ready", 1'b1, in_ready);
        run_pass(1'b0);
        run_pass(1'b1);
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d accepted words never came out", exp_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/act_pkg.sv
hdl/gelu_pipe_ctrl.sv
hdl/gelu_coef_lut.sv
hdl/gelu_range_classify.sv
hdl/gelu_poly_eval.sv
hdl/gelu_unit.sv
verification/gelu_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= gelu_unit_tb
DUT_TOP   ?= gelu_unit
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail is taken from the simulator output only.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
